//--- verilog/victim_settings.svh
`ifndef VICTIM_SETTINGS_SVH
`define VICTIM_SETTINGS_SVH

// victim buffer geometry
`define VIC_SIZE        4

// address split of an L1 line
`define NUM_SET_BITS    6
`define NUM_TAG_BITS    10

// line payload width
`define LINE_BITS       64

// lookup ports served in the same cycle
`define RD_PORTS        2

// intake queue depth, also the L1's starting credit
`define VIC_IN_CREDITS  2

// writeback queue and memory-side flow control
`define WB_DEPTH        4
`define MEM_CREDITS     2

`endif

//--- verilog/victim_pkg.sv
`include "victim_settings.svh"

package victim_pkg;

    // one buffered victim line
    typedef struct packed {
        logic                       valid;
        logic                       dirty;
        logic [`NUM_SET_BITS-1:0]   index;
        logic [`NUM_TAG_BITS-1:0]   tag;
        logic [`LINE_BITS-1:0]      data;
    } victim_entry_t;

    typedef struct packed {
        logic                       en;
        logic [`NUM_SET_BITS-1:0]   index;
        logic [`NUM_TAG_BITS-1:0]   tag;
    } lookup_req_t;

    typedef struct packed {
        logic                       hit;
        logic                       dirty;
        logic [`LINE_BITS-1:0]      data;
    } lookup_rsp_t;

    // full line address, tag above index
    typedef struct packed {
        logic [`NUM_TAG_BITS-1:0]   tag;
        logic [`NUM_SET_BITS-1:0]   index;
        logic [`LINE_BITS-1:0]      data;
    } writeback_t;

endpackage

//--- verilog/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     not_full,
    output logic     credit
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign not_full  = (count != CNT_W'(DEPTH));

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per freed slot
            credit <= pop;
        end
    end

    // producer must respect the credits it was given
    a_no_overflow: assert property (@(posedge clock) disable iff (reset) push |-> not_full)
        else $error("credit_fifo: push while full");
    a_no_underflow: assert property (@(posedge clock) disable iff (reset) pop |-> not_empty)
        else $error("credit_fifo: pop while empty");

endmodule

//--- verilog/victim_buffer.sv
`timescale 1ns/1ps
`include "victim_settings.svh"

module victim_buffer (
    input  logic                                      clock,
    input  logic                                      reset,
    input  victim_pkg::victim_entry_t                 in_entry,
    input  logic                                      in_ready,
    input  victim_pkg::lookup_req_t [`RD_PORTS-1:0]   lookup,
    input  logic                                      wb_space,
    output logic                                      take,
    output victim_pkg::lookup_rsp_t [`RD_PORTS-1:0]   lookup_rsp,
    output logic                                      wb_push,
    output victim_pkg::writeback_t                    wb_data
);
    localparam int IDX_W = $clog2(`VIC_SIZE);
    localparam int CNT_W = $clog2(`VIC_SIZE + 1);

    // slot 0 holds the oldest entry
    victim_pkg::victim_entry_t [`VIC_SIZE-1:0] entries;
    victim_pkg::victim_entry_t [`VIC_SIZE-1:0] shifted;
    victim_pkg::victim_entry_t [`VIC_SIZE-1:0] entries_next;
    victim_pkg::victim_entry_t                 new_entry;
    victim_pkg::victim_entry_t                 oldest;
    logic [CNT_W-1:0]                          tail;
    logic [CNT_W-1:0]                          kept;
    logic [CNT_W-1:0]                          tail_next;
    logic [`RD_PORTS-1:0][`VIC_SIZE-1:0]       match;
    logic [`VIC_SIZE-1:0]                      hit_any;
    logic                                      push_out;

    // associative compare per port
    always_comb begin
        hit_any = '0;
        for (int p = 0; p < `RD_PORTS; p++) begin
            for (int i = 0; i < `VIC_SIZE; i++) begin
                match[p][i] = lookup[p].en && entries[i].valid &&
                              (entries[i].index == lookup[p].index) &&
                              (entries[i].tag == lookup[p].tag);
            end
            hit_any = hit_any | match[p];
        end
    end

    // priority encode so the lowest slot wins
    always_comb begin
        for (int p = 0; p < `RD_PORTS; p++) begin
            lookup_rsp[p] = '0;
            for (int i = `VIC_SIZE - 1; i >= 0; i--) begin
                if (match[p][i]) begin
                    lookup_rsp[p].hit   = 1'b1;
                    lookup_rsp[p].dirty = entries[i].dirty;
                    lookup_rsp[p].data  = entries[i].data;
                end
            end
        end
    end

    // drop hit entries and close the gaps toward slot 0
    always_comb begin
        shifted = '0;
        kept    = '0;
        for (int i = 0; i < `VIC_SIZE; i++) begin
            if (entries[i].valid && !hit_any[i]) begin
                shifted[kept[IDX_W-1:0]] = entries[i];
                kept = kept + 1'b1;
            end
        end
    end

    assign new_entry = '{valid: 1'b1,
                         dirty: in_entry.dirty,
                         index: in_entry.index,
                         tag:   in_entry.tag,
                         data:  in_entry.data};

    // take when a slot is free or a push-out can land in the writeback queue
    assign take     = in_ready && ((kept < CNT_W'(`VIC_SIZE)) || wb_space);
    assign push_out = take && (kept == CNT_W'(`VIC_SIZE));
    assign oldest   = shifted[0];

    // clean lines leave silently
    assign wb_push  = push_out && oldest.dirty;
    assign wb_data  = '{tag: oldest.tag, index: oldest.index, data: oldest.data};

    always_comb begin
        entries_next = shifted;
        tail_next    = kept;
        if (push_out) begin
            for (int i = 0; i < `VIC_SIZE - 1; i++) begin
                entries_next[i] = shifted[i+1];
            end
            entries_next[`VIC_SIZE-1] = new_entry;
        end else if (take) begin
            entries_next[kept[IDX_W-1:0]] = new_entry;
            tail_next = kept + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
            tail    <= '0;
        end else begin
            entries <= entries_next;
            tail    <= tail_next;
        end
    end

    // valid slots form one run from slot 0 whose length is the tail count
    for (genvar i = 0; i < `VIC_SIZE; i++) begin : g_tail
        a_tail_bound: assert property (@(posedge clock) disable iff (reset)
            tail <= CNT_W'(`VIC_SIZE) && entries[i].valid == (CNT_W'(i) < tail))
            else $error("victim_buffer: slot %0d disagrees with tail count", i);
    end

    // the L1 never evicts a line that is still held here
    for (genvar i = 0; i < `VIC_SIZE; i++) begin : g_uniq_row
        for (genvar j = i + 1; j < `VIC_SIZE; j++) begin : g_uniq_col
            a_unique: assert property (@(posedge clock) disable iff (reset)
                !(entries[i].valid && entries[j].valid &&
                  entries[i].index == entries[j].index &&
                  entries[i].tag == entries[j].tag))
                else $error("victim_buffer: slots %0d and %0d share an address", i, j);
        end
    end

endmodule

//--- verilog/writeback_sender.sv
`timescale 1ns/1ps
`include "victim_settings.svh"

module writeback_sender (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   push,
    input  victim_pkg::writeback_t push_data,
    input  logic                   mem_credit,
    output logic                   space,
    output logic                   mem_valid,
    output victim_pkg::writeback_t mem_wb
);
    localparam int CRED_W = $clog2(`MEM_CREDITS + 1);

    logic [CRED_W-1:0] credits;
    logic              q_not_empty;
    logic              send;

    // dirty lines wait here for memory credit
    credit_fifo #(
        .payload_t (victim_pkg::writeback_t),
        .DEPTH     (`WB_DEPTH)
    ) i_wb_fifo (
        .clock     (clock),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (send),
        .head      (mem_wb),
        .not_empty (q_not_empty),
        .not_full  (space),
        .credit    ()
    );

    assign send      = q_not_empty && (credits != '0);
    assign mem_valid = send;

    // spend one per send, regain one per returned credit
    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= CRED_W'(`MEM_CREDITS);
        end else begin
            credits <= credits + CRED_W'(mem_credit) - CRED_W'(send);
        end
    end

    // memory returns no more than it was sent
    a_credit_bound: assert property (@(posedge clock) disable iff (reset)
        credits <= CRED_W'(`MEM_CREDITS))
        else $error("writeback_sender: memory credit count above limit");

endmodule

//--- verilog/victim_cache_top.sv
`timescale 1ns/1ps
`include "victim_settings.svh"

module victim_cache_top (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    victim_valid,
    input  victim_pkg::victim_entry_t               victim,
    input  victim_pkg::lookup_req_t [`RD_PORTS-1:0] lookup,
    input  logic                                    mem_credit,
    output logic                                    victim_credit,
    output victim_pkg::lookup_rsp_t [`RD_PORTS-1:0] lookup_rsp,
    output logic                                    mem_valid,
    output victim_pkg::writeback_t                  mem_wb
);
    victim_pkg::victim_entry_t intake_head;
    victim_pkg::writeback_t    wb_data;
    logic                      intake_not_empty;
    logic                      take;
    logic                      wb_push;
    logic                      wb_space;

    // L1 evictions, credit controlled so no ready is needed
    credit_fifo #(
        .payload_t (victim_pkg::victim_entry_t),
        .DEPTH     (`VIC_IN_CREDITS)
    ) i_intake (
        .clock     (clock),
        .reset     (reset),
        .push      (victim_valid),
        .push_data (victim),
        .pop       (take),
        .head      (intake_head),
        .not_empty (intake_not_empty),
        .not_full  (),
        .credit    (victim_credit)
    );

    victim_buffer i_buffer (
        .clock      (clock),
        .reset      (reset),
        .in_entry   (intake_head),
        .in_ready   (intake_not_empty),
        .lookup     (lookup),
        .wb_space   (wb_space),
        .take       (take),
        .lookup_rsp (lookup_rsp),
        .wb_push    (wb_push),
        .wb_data    (wb_data)
    );

    writeback_sender i_sender (
        .clock      (clock),
        .reset      (reset),
        .push       (wb_push),
        .push_data  (wb_data),
        .mem_credit (mem_credit),
        .space      (wb_space),
        .mem_valid  (mem_valid),
        .mem_wb     (mem_wb)
    );

endmodule

//--- tests/victim_cache_tb.sv
`timescale 1ns/1ps
`include "victim_settings.svh"

module victim_cache_tb;

    localparam int NUM_RAND    = `VIC_SIZE + 3;
    // enough victims to fill buffer, writeback queue, memory credits and intake
    localparam int STALL_SENDS = `VIC_SIZE + `WB_DEPTH + `MEM_CREDITS + `VIC_IN_CREDITS;
    // sends and lookup calls over all tests
    localparam int NUM_OPS     = 2 + 4 + 2 * NUM_RAND + STALL_SENDS;
    localparam int MAX_CYCLES  = 40 * NUM_OPS;

    logic                                    clock;
    logic                                    reset;
    logic                                    victim_valid;
    victim_pkg::victim_entry_t               victim;
    victim_pkg::lookup_req_t [`RD_PORTS-1:0] lookup;
    logic                                    mem_credit = 1'b0;
    logic                                    victim_credit;
    victim_pkg::lookup_rsp_t [`RD_PORTS-1:0] lookup_rsp;
    logic                                    mem_valid;
    victim_pkg::writeback_t                  mem_wb;

    victim_pkg::victim_entry_t model[$];
    victim_pkg::writeback_t    exp_wb[$];
    string                     test_name;
    logic                      hold_mem;
    logic [`NUM_TAG_BITS-1:0]  next_tag;
    int errors = 0;
    int returned = 0;
    int mem_owed = 0;
    int wb_count = 0;
    int wb_expected = 0;
    int cycle = 0;
    int sent;
    int stim_errors;

    victim_cache_top i_dut (
        .clock         (clock),
        .reset         (reset),
        .victim_valid  (victim_valid),
        .victim        (victim),
        .lookup        (lookup),
        .mem_credit    (mem_credit),
        .victim_credit (victim_credit),
        .lookup_rsp    (lookup_rsp),
        .mem_valid     (mem_valid),
        .mem_wb        (mem_wb)
    );

    always #4 clock = ~clock;

    function automatic int find_entry(input logic [`NUM_SET_BITS-1:0] index,
                                      input logic [`NUM_TAG_BITS-1:0] tag);
        for (int i = 0; i < model.size(); i++) begin
            if (model[i].index == index && model[i].tag == tag) return i;
        end
        return -1;
    endfunction

    // expected lookup answer from the model queue
    function automatic victim_pkg::lookup_rsp_t ref_lookup(input victim_pkg::lookup_req_t req);
        victim_pkg::lookup_rsp_t rsp;
        int                      pos;
        rsp = '0;
        pos = req.en ? find_entry(req.index, req.tag) : -1;
        if (pos >= 0) begin
            rsp.hit   = 1'b1;
            rsp.dirty = model[pos].dirty;
            rsp.data  = model[pos].data;
        end
        return rsp;
    endfunction

    function automatic victim_pkg::lookup_req_t make_req(input logic [`NUM_SET_BITS-1:0] index,
                                                         input logic [`NUM_TAG_BITS-1:0] tag);
        victim_pkg::lookup_req_t req;
        req.en    = 1'b1;
        req.index = index;
        req.tag   = tag;
        return req;
    endfunction

    // oldest leaves once the model overflows and dirty ones are owed to memory
    task automatic model_insert(input victim_pkg::victim_entry_t e);
        victim_pkg::victim_entry_t old;
        victim_pkg::writeback_t    wb;
        model.push_back(e);
        if (model.size() > `VIC_SIZE) begin
            old = model.pop_front();
            if (old.dirty) begin
                wb.tag   = old.tag;
                wb.index = old.index;
                wb.data  = old.data;
                exp_wb.push_back(wb);
                wb_expected++;
            end
        end
    endtask

    task automatic send_victim(input logic dirty, input logic [`NUM_SET_BITS-1:0] index,
                               output logic [`NUM_TAG_BITS-1:0] tag);
        victim_pkg::victim_entry_t e;
        e.valid  = 1'b1;
        e.dirty  = dirty;
        e.index  = index;
        e.tag    = next_tag;
        e.data   = {$urandom, $urandom};
        tag      = next_tag;
        next_tag = next_tag + 1'b1;
        @(posedge clock);
        while (sent - returned >= `VIC_IN_CREDITS) @(posedge clock);
        victim_valid <= 1'b1;
        victim       <= e;
        sent         <= sent + 1;
        @(posedge clock);
        victim_valid <= 1'b0;
    endtask

    task automatic lookup_pair(input victim_pkg::lookup_req_t r0,
                               input victim_pkg::lookup_req_t r1, input int cycles);
        @(posedge clock);
        lookup[0] <= r0;
        lookup[1] <= r1;
        repeat (cycles) @(posedge clock);
        lookup <= '0;
    endtask

    // every victim taken and every writeback answered
    task automatic drain();
        @(posedge clock);
        while (exp_wb.size() != 0 || sent != returned || mem_owed != 0) @(posedge clock);
        repeat (3) @(posedge clock);
    endtask

    always @(posedge clock) begin : check_outputs
        victim_pkg::lookup_rsp_t exp_rsp [`RD_PORTS];
        int                      owed;
        int                      pos;
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, errors: %0d", cycle, errors);
            $display("Errors found");
            $finish;
        end else if (!reset) begin
            if (victim_credit) begin
                assert (returned < sent) else begin
                    $display("input credit returned with no victim outstanding");
                    errors++;
                end
                returned <= returned + 1;
            end
            for (int p = 0; p < `RD_PORTS; p++) begin
                exp_rsp[p] = ref_lookup(lookup[p]);
                assert (lookup_rsp[p] == exp_rsp[p]) else begin
                    $display("ERR %s port %0d: expected %h actual %h",
                             test_name, p, exp_rsp[p], lookup_rsp[p]);
                    errors++;
                end
            end
            // a hit line moves back to the L1
            for (int p = 0; p < `RD_PORTS; p++) begin
                pos = exp_rsp[p].hit ? find_entry(lookup[p].index, lookup[p].tag) : -1;
                if (pos >= 0) model.delete(pos);
            end
            if (victim_valid) model_insert(victim);
            owed = mem_owed;
            if (mem_valid) begin
                owed++;
                wb_count++;
                assert (exp_wb.size() != 0) else begin
                    $display("writeback sent to memory with none expected");
                    errors++;
                end
                if (exp_wb.size() != 0) begin
                    assert (mem_wb == exp_wb[0]) else begin
                        $display("ERR %s writeback: expected %h actual %h",
                                 test_name, exp_wb[0], mem_wb);
                        errors++;
                    end
                    exp_wb.delete(0);
                end
            end
            assert (owed <= `MEM_CREDITS) else begin
                $display("more writebacks outstanding than memory credits");
                errors++;
            end
            // memory answers one item per cycle unless held back
            mem_credit <= !hold_mem && owed > 0;
            mem_owed   <= (!hold_mem && owed > 0) ? owed - 1 : owed;
        end
    end

    initial begin
        logic [31:0]              rnd;
        logic [`NUM_TAG_BITS-1:0] tag0;
        logic [`NUM_TAG_BITS-1:0] tag1;
        logic [`NUM_SET_BITS-1:0] addr_index [NUM_RAND];
        logic [`NUM_TAG_BITS-1:0] addr_tag [NUM_RAND];
        void'($urandom(32'hf893));
        clock        = 1'b0;
        reset        = 1'b1;
        victim_valid = 1'b0;
        victim       = '0;
        lookup       = '0;
        hold_mem     = 1'b0;
        next_tag     = 10'd1;
        sent         = 0;
        stim_errors  = 0;
        test_name    = "reset";
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        assert (!victim_credit && !mem_valid) else begin
            $display("credit or memory valid high after reset");
            stim_errors++;
        end

        test_name <= "single_insert";
        send_victim(1'b1, 6'h05, tag0);
        drain();
        lookup_pair(make_req(6'h05, tag0), '0, 2);

        test_name <= "dual_port";
        lookup_pair(make_req(6'h11, 10'h3ff), make_req(6'h22, 10'h3fe), 1);
        send_victim(1'b0, 6'h11, tag0);
        send_victim(1'b1, 6'h22, tag1);
        drain();
        lookup_pair(make_req(6'h11, tag0), make_req(6'h22, tag1), 2);

        test_name <= "push_out";
        for (int i = 0; i < NUM_RAND; i++) begin
            rnd           = $urandom;
            addr_index[i] = rnd[`NUM_SET_BITS-1:0];
            send_victim(rnd[16], addr_index[i], addr_tag[i]);
        end
        drain();
        for (int i = 0; i < NUM_RAND; i++) begin
            lookup_pair(make_req(addr_index[i], addr_tag[i]), '0, 1);
        end

        test_name <= "input_credits";
        hold_mem  <= 1'b1;
        for (int i = 0; i < STALL_SENDS; i++) begin
            rnd = $urandom;
            send_victim(1'b1, rnd[`NUM_SET_BITS-1:0], tag0);
        end
        // settle window for the stalled pipeline
        repeat (20) @(posedge clock);
        assert (sent - returned == `VIC_IN_CREDITS) else begin
            $display("input credits kept returning while memory was stalled");
            stim_errors++;
        end
        hold_mem <= 1'b0;
        drain();

        test_name = "mem_credits";
        assert (wb_count == wb_expected) else begin
            $display("ERR %s count: expected %0d actual %0d", test_name, wb_expected, wb_count);
            stim_errors++;
        end

        $display("errors: %0d output checks, %0d stimulus checks", errors, stim_errors);
        if (errors == 0 && stim_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+verilog
verilog/victim_pkg.sv
verilog/credit_fifo.sv
verilog/victim_buffer.sv
verilog/writeback_sender.sv
verilog/victim_cache_top.sv
tests/victim_cache_tb.sv

//--- Makefile
TOP = victim_cache_tb

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
